/* source/ni_pkg.sv */
package ni_pkg;

  localparam int NumVirtChn    = 4;                   // Virtual channels on the router port
  localparam int VcWidth       = $clog2(NumVirtChn);  // Bits of the channel number
  localparam int BufDepth      = 8;                   // Flits held per receive buffer
  localparam int BufPtrWidth   = $clog2(BufDepth);    // Read and write pointer width
  localparam int OcupWidth     = 4;                   // Occupancy count reaches BufDepth
  localparam int PktWidth      = 8;                   // Packet size carried by a head flit
  localparam int FlitDataWidth = 32;                  // Payload bits of one flit
  localparam int XWidth        = 4;                   // Router column coordinate width
  localparam int YWidth        = 4;                   // Router row coordinate width
  localparam int CsrAddrWidth  = 16;                  // Offset address from the bus side
  localparam int CsrDataWidth  = 32;                  // CSR read and write data width

  // Flit kind as sent by the router
  typedef enum logic [1:0] {
    HEAD_FLIT      = 2'b00,  // Opens a packet and carries its size
    BODY_FLIT      = 2'b01,  // Payload in the middle of a packet
    TAIL_FLIT      = 2'b10,  // Closes a packet
    HEAD_TAIL_FLIT = 2'b11   // Single flit packet
  } flit_type_t;

  typedef struct packed {
    flit_type_t                ftype;  // Kind of flit
    logic [FlitDataWidth-1:0]  data;   // Payload bits
  } s_flit_t;

  // Interrupt source selection written through CSR_IRQ_MUX
  typedef enum logic [2:0] {
    MUX_DEFAULT     = 3'd0,  // Any channel with data
    MUX_EMPTY_FLAGS = 3'd1,  // Not empty qualified by mask bit 0
    MUX_FULL_FLAGS  = 3'd2,  // Full qualified by mask bit 0
    MUX_COMP_FLAGS  = 3'd3,  // Occupancy compared against the mask value
    PULSE_HEAD_FLIT = 3'd4   // Head flit waiting at the buffer output
  } irq_mux_t;

  localparam logic [CsrAddrWidth-1:0] CSR_VERSION       = 16'h0000;  // Read only label
  localparam logic [CsrAddrWidth-1:0] CSR_ROUTER_X      = 16'h0004;  // Read only column
  localparam logic [CsrAddrWidth-1:0] CSR_ROUTER_Y      = 16'h0008;  // Read only row
  localparam logic [CsrAddrWidth-1:0] CSR_IRQ_STATUS    = 16'h000C;  // Per channel interrupts
  localparam logic [CsrAddrWidth-1:0] CSR_IRQ_MUX       = 16'h0010;  // Interrupt mode
  localparam logic [CsrAddrWidth-1:0] CSR_IRQ_MASK      = 16'h0014;  // Mask or threshold
  localparam logic [CsrAddrWidth-1:0] CSR_BUF_FULL      = 16'h0018;  // Full flag vector
  localparam logic [CsrAddrWidth-1:0] CSR_PKT_SIZE_BASE = 16'h0020;  // First packet size slot
  localparam logic [CsrAddrWidth-1:0] CSR_RD_DATA_BASE  = 16'h0040;  // First flit pop slot
  localparam logic [CsrAddrWidth-1:0] CSR_CHN_STRIDE    = 16'h0004;  // Spacing of channel slots

  localparam logic [CsrDataWidth-1:0] RxVersionLabel = 32'h0052_5831;  // Reads back as "RX1"

endpackage

/* source/vc_buf_if.sv */
interface vc_buf_if
  import ni_pkg::*;
();

  logic                 wr_en;     // Push strobe from the demux
  s_flit_t              wr_flit;   // Flit to be stored
  logic                 pop;       // Pop strobe from the CSR block
  s_flit_t              rd_flit;   // Oldest flit in the buffer
  logic                 empty;     // No flit stored
  logic                 full;      // All entries in use
  logic [OcupWidth-1:0] ocup;      // Number of stored flits
  logic [PktWidth-1:0]  pkt_size;  // Size field of the newest head flit

  modport demux_mp (
    output wr_en,
    output wr_flit,
    input  full
  );

  modport buf_mp (
    input  wr_en, wr_flit, pop,
    output rd_flit, empty, full, ocup, pkt_size
  );

  modport csr_mp (
    output pop,
    input  rd_flit, empty, full, ocup, pkt_size
  );

endinterface

/* source/flit_vc_demux.sv */
module flit_vc_demux
  import ni_pkg::*;
(
  input  logic               flit_valid_i,         // Router offers a flit
  input  logic [VcWidth-1:0] flit_vc_i,            // Channel the flit belongs to
  input  s_flit_t            flit_i,               // Flit type and payload
  output logic               flit_ready_o,         // Selected channel can take the flit
  vc_buf_if.demux_mp         bufs [NumVirtChn]     // One write port per receive buffer
);

  logic [NumVirtChn-1:0] full_vec;  // Full flags gathered from the buffers
  logic [NumVirtChn-1:0] sel_vec;   // One hot channel select qualified by valid

  // Decode the channel number into a single select bit
  always_comb begin
    sel_vec            = '0;
    sel_vec[flit_vc_i] = flit_valid_i;  // Only the addressed channel sees the offer
  end

  // Ready depends only on the addressed buffer so a stalled channel
  // does not hold back traffic to the others
  assign flit_ready_o = ~full_vec[flit_vc_i];

  for (genvar i = 0; i < NumVirtChn; i++) begin : g_chn
    assign full_vec[i]     = bufs[i].full;               // Status back from the buffer
    assign bufs[i].wr_en   = sel_vec[i] & ~full_vec[i];  // Push only on an accepted flit
    assign bufs[i].wr_flit = flit_i;                     // Same flit goes to every buffer
  end

endmodule

/* source/vc_rx_buffer.sv */
module vc_rx_buffer
  import ni_pkg::*;
(
  input  logic     clk_axi,   // Bus clock
  input  logic     arst_axi,  // Asynchronous reset active high
  vc_buf_if.buf_mp bif        // Write, pop and status of this channel
);

  s_flit_t              mem [BufDepth];  // Flit storage
  logic [BufPtrWidth-1:0] wr_ptr_ff;     // Next free entry
  logic [BufPtrWidth-1:0] rd_ptr_ff;     // Oldest stored entry
  logic [OcupWidth-1:0]   ocup_ff;       // Stored flit count
  logic [PktWidth-1:0]    pkt_size_ff;   // Size from the newest head flit
  logic                   push;          // Write that is allowed to land
  logic                   pop_ok;        // Pop that has a flit to remove
  logic                   head_in;       // Incoming flit opens a packet

  // Advance a pointer around the ring
  function automatic logic [BufPtrWidth-1:0] next_ptr(input logic [BufPtrWidth-1:0] ptr);
    logic [BufPtrWidth-1:0] nxt;
    if (ptr == BufPtrWidth'(BufDepth - 1)) begin
      nxt = '0;  // Wrap back to the first entry
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign push    = bif.wr_en & ~bif.full;  // A full buffer never overwrites
  assign pop_ok  = bif.pop & ~bif.empty;   // Popping an empty buffer does nothing
  assign head_in = (bif.wr_flit.ftype == HEAD_FLIT) ||
                   (bif.wr_flit.ftype == HEAD_TAIL_FLIT);

  // Storage write
  always_ff @(posedge clk_axi) begin
    if (push) begin
      mem[wr_ptr_ff] <= bif.wr_flit;  // Flit lands at the write pointer
    end
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr_ff   <= '0;
      rd_ptr_ff   <= '0;
      ocup_ff     <= '0;
      pkt_size_ff <= '0;
    end else begin
      if (push) begin
        wr_ptr_ff <= next_ptr(wr_ptr_ff);
      end
      if (pop_ok) begin
        rd_ptr_ff <= next_ptr(rd_ptr_ff);
      end
      // Push and pop in the same cycle leave the count unchanged
      case ({push, pop_ok})
        2'b10:   ocup_ff <= ocup_ff + 1'b1;
        2'b01:   ocup_ff <= ocup_ff - 1'b1;
        default: ocup_ff <= ocup_ff;
      endcase
      if (push && head_in) begin
        pkt_size_ff <= bif.wr_flit.data[PktWidth-1:0];  // Low byte of a head is the size
      end
    end
  end

  assign bif.rd_flit  = mem[rd_ptr_ff];                    // Head is visible without a pop
  assign bif.empty    = (ocup_ff == '0);
  assign bif.full     = (ocup_ff == OcupWidth'(BufDepth));
  assign bif.ocup     = ocup_ff;
  assign bif.pkt_size = pkt_size_ff;

endmodule

/* source/ni_csr.sv */
module ni_csr
  import ni_pkg::*;
#(
  parameter logic [XWidth-1:0] router_x_id = '0,  // Column of the attached router
  parameter logic [YWidth-1:0] router_y_id = '0   // Row of the attached router
) (
  input  logic                    clk_axi,           // Bus clock
  input  logic                    arst_axi,          // Asynchronous reset active high
  input  logic                    csr_valid_i,       // Request strobe
  input  logic                    csr_wr_i,          // High for a write and low for a read
  input  logic [CsrAddrWidth-1:0] csr_addr_i,        // Offset address
  input  logic [CsrDataWidth-1:0] csr_wdata_i,       // Write data
  output logic [CsrDataWidth-1:0] csr_rdata_o,       // Registered read data
  output logic                    csr_err_o,         // Read or write error
  output logic [NumVirtChn-1:0]   irq_vcs_o,         // Per channel interrupt lines
  output logic                    irq_trig_o,        // Any channel interrupt
  vc_buf_if.csr_mp                bufs [NumVirtChn]  // Pop and status of every buffer
);

  logic [NumVirtChn-1:0]                empty_vec;    // Empty flags
  logic [NumVirtChn-1:0]                full_vec;     // Full flags
  logic [NumVirtChn-1:0]                pop_vec;      // Pop strobes to the buffers
  logic [NumVirtChn-1:0][OcupWidth-1:0] ocup_vec;     // Occupancy counts
  logic [NumVirtChn-1:0][PktWidth-1:0]  pkt_vec;      // Latest packet sizes
  s_flit_t [NumVirtChn-1:0]             head_vec;     // Flits at the buffer outputs
  logic                                 rd_req;       // Read strobe
  logic                                 wr_req;       // Write strobe
  logic                                 err_wr;       // Write to a read only or unmapped slot
  logic                                 err_rd;       // Read that could not be served
  logic                                 err_ff;       // Error of the last read
  logic                                 next_err;
  logic [CsrDataWidth-1:0]              rdata_ff;     // Readout register
  logic [CsrDataWidth-1:0]              next_rdata;
  irq_mux_t                             irq_mux_ff;   // Interrupt mode
  irq_mux_t                             next_irq_mux;
  logic [CsrDataWidth-1:0]              irq_mask_ff;  // Mask or occupancy threshold
  logic [CsrDataWidth-1:0]              next_irq_mask;

  // Address of the channel slot idx above a base offset
  function automatic logic [CsrAddrWidth-1:0] chn_addr(input logic [CsrAddrWidth-1:0] base,
                                                       input int idx);
    return base + CsrAddrWidth'(idx) * CSR_CHN_STRIDE;
  endfunction

  // Interface arrays take constant indices so status is gathered into vectors
  for (genvar i = 0; i < NumVirtChn; i++) begin : g_chn
    assign empty_vec[i] = bufs[i].empty;
    assign full_vec[i]  = bufs[i].full;
    assign ocup_vec[i]  = bufs[i].ocup;
    assign pkt_vec[i]   = bufs[i].pkt_size;
    assign head_vec[i]  = bufs[i].rd_flit;
    assign bufs[i].pop  = pop_vec[i];  // Pop lands on the same edge as the readout
  end

  assign rd_req = csr_valid_i & ~csr_wr_i;
  assign wr_req = csr_valid_i & csr_wr_i;

  always_comb begin : write_decode
    err_wr        = 1'b0;
    next_irq_mux  = irq_mux_ff;
    next_irq_mask = irq_mask_ff;
    if (wr_req) begin
      case (csr_addr_i)
        CSR_IRQ_MUX:  next_irq_mux  = irq_mux_t'(csr_wdata_i[2:0]);  // Only the mode bits
        CSR_IRQ_MASK: next_irq_mask = csr_wdata_i;
        default:      err_wr        = 1'b1;  // Everything else is read only or unmapped
      endcase
    end
  end

  always_comb begin : read_decode
    err_rd     = 1'b0;
    next_rdata = rdata_ff;  // An unserved read keeps the old data
    pop_vec    = '0;
    if (rd_req) begin
      case (csr_addr_i)
        CSR_VERSION:    next_rdata = RxVersionLabel;
        CSR_ROUTER_X:   next_rdata = CsrDataWidth'(router_x_id);
        CSR_ROUTER_Y:   next_rdata = CsrDataWidth'(router_y_id);
        CSR_IRQ_STATUS: next_rdata = CsrDataWidth'(irq_vcs_o);
        CSR_IRQ_MUX:    next_rdata = CsrDataWidth'(irq_mux_ff);
        CSR_IRQ_MASK:   next_rdata = irq_mask_ff;
        CSR_BUF_FULL:   next_rdata = CsrDataWidth'(full_vec);
        default: begin
          err_rd = 1'b1;  // Cleared below if a channel slot matches
          for (int i = 0; i < NumVirtChn; i++) begin
            if (csr_addr_i == chn_addr(CSR_PKT_SIZE_BASE, i)) begin
              next_rdata = CsrDataWidth'(pkt_vec[i]);
              err_rd     = 1'b0;
            end
            if (csr_addr_i == chn_addr(CSR_RD_DATA_BASE, i)) begin
              err_rd = empty_vec[i];  // Nothing to pop on an empty channel
              if (!empty_vec[i]) begin
                next_rdata = head_vec[i].data;
                pop_vec[i] = 1'b1;
              end
            end
          end
        end
      endcase
    end
  end

  // Read error follows each read and holds until the next one
  assign next_err = rd_req ? err_rd : err_ff;

  always_comb begin : irq_select
    irq_vcs_o = '0;
    for (int i = 0; i < NumVirtChn; i++) begin
      case (irq_mux_ff)
        MUX_EMPTY_FLAGS: irq_vcs_o[i] = ~empty_vec[i] & irq_mask_ff[0];
        MUX_FULL_FLAGS:  irq_vcs_o[i] = full_vec[i] & irq_mask_ff[0];
        MUX_COMP_FLAGS:  irq_vcs_o[i] = (CsrDataWidth'(ocup_vec[i]) >= irq_mask_ff);
        PULSE_HEAD_FLIT: irq_vcs_o[i] = ~empty_vec[i] &&
                                        ((head_vec[i].ftype == HEAD_FLIT) ||
                                         (head_vec[i].ftype == HEAD_TAIL_FLIT));
        default:         irq_vcs_o[i] = ~empty_vec[i];  // Also covers undefined modes
      endcase
    end
  end

  assign irq_trig_o = |irq_vcs_o;

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      err_ff      <= 1'b0;
      rdata_ff    <= '0;
      irq_mux_ff  <= MUX_DEFAULT;
      irq_mask_ff <= '1;  // All ones keeps the qualified modes enabled
    end else begin
      err_ff      <= next_err;
      rdata_ff    <= next_rdata;
      irq_mux_ff  <= next_irq_mux;
      irq_mask_ff <= next_irq_mask;
    end
  end

  assign csr_rdata_o = rdata_ff;
  assign csr_err_o   = err_ff | err_wr;  // Write errors show in the strobe cycle

endmodule

/* source/ni_rx_top.sv */
module ni_rx_top
  import ni_pkg::*;
#(
  parameter logic [XWidth-1:0] router_x_id = '0,  // Column of this node
  parameter logic [YWidth-1:0] router_y_id = '0   // Row of this node
) (
  input  logic                     clk_axi,       // Bus clock
  input  logic                     arst_axi,      // Asynchronous reset active high
  input  logic                     flit_valid_i,  // Router offers a flit
  input  logic [VcWidth-1:0]       flit_vc_i,     // Virtual channel of the flit
  input  flit_type_t               flit_type_i,   // Head, body, tail or head-tail
  input  logic [FlitDataWidth-1:0] flit_data_i,   // Flit payload
  output logic                     flit_ready_o,  // Addressed channel has room
  input  logic                     csr_valid_i,   // CSR request strobe
  input  logic                     csr_wr_i,      // CSR write when high
  input  logic [CsrAddrWidth-1:0]  csr_addr_i,    // CSR offset address
  input  logic [CsrDataWidth-1:0]  csr_wdata_i,   // CSR write data
  output logic [CsrDataWidth-1:0]  csr_rdata_o,   // CSR read data
  output logic                     csr_err_o,     // CSR error
  output logic [NumVirtChn-1:0]    irq_vcs_o,     // Per channel interrupts
  output logic                     irq_trig_o     // Combined interrupt
);

  s_flit_t  flit_in;                // Incoming flit packed into one word
  vc_buf_if bufs [NumVirtChn] ();   // One buffer bundle per channel

  assign flit_in.ftype = flit_type_i;
  assign flit_in.data  = flit_data_i;

  flit_vc_demux u_demux (
    .flit_valid_i (flit_valid_i),
    .flit_vc_i    (flit_vc_i),
    .flit_i       (flit_in),
    .flit_ready_o (flit_ready_o),
    .bufs         (bufs)
  );

  for (genvar i = 0; i < NumVirtChn; i++) begin : g_vc_buf
    vc_rx_buffer u_buf (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .bif      (bufs[i])
    );
  end

  ni_csr #(
    .router_x_id (router_x_id),
    .router_y_id (router_y_id)
  ) u_csr (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .csr_valid_i (csr_valid_i),
    .csr_wr_i    (csr_wr_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .csr_err_o   (csr_err_o),
    .irq_vcs_o   (irq_vcs_o),
    .irq_trig_o  (irq_trig_o),
    .bufs        (bufs)
  );

endmodule

/* bench/ni_rx_tb.sv */
module ni_rx_tb
  import ni_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          WaitLimit = 20;            // Cycles a flit may wait for ready
  localparam logic [31:0] Seed      = 32'h3681_b33c; // Seed for the idle gaps
  localparam string       StimFile  = "bench/ni_rx_stimulus.txt";

  logic                     clk_axi;
  logic                     arst_axi;
  logic                     flit_valid;
  logic [VcWidth-1:0]       flit_vc;
  flit_type_t               flit_type;
  logic [FlitDataWidth-1:0] flit_data;
  logic                     flit_ready;
  logic                     csr_valid;
  logic                     csr_wr;
  logic [CsrAddrWidth-1:0]  csr_addr;
  logic [CsrDataWidth-1:0]  csr_wdata;
  logic [CsrDataWidth-1:0]  csr_rdata;
  logic                     csr_err;
  logic [NumVirtChn-1:0]    irq_vcs;
  logic                     irq_trig;

  int              errors;       // Failed checks
  int              checks;       // Checks done
  int              cycles;       // Clock edges since time zero
  int              cycle_limit;  // Set once the stimulus length is known
  bit              hold_pend;    // A held flit is still on offer
  bit              ready_seen;   // Offer and ready were both high at the last falling edge
  int              fd;
  int              code;
  int              nlines;
  int              gap;
  int unsigned     rnd;
  string           tname;        // Test name of the current line
  string           cmd;
  logic [31:0]     op_a;
  logic [31:0]     op_b;
  logic [31:0]     op_c;
  logic [8*160-1:0] line_buf;    // Skipped text of a line

  ni_rx_top #(
    .router_x_id (4'd2),
    .router_y_id (4'd3)
  ) UUT (
    .clk_axi      (clk_axi),
    .arst_axi     (arst_axi),
    .flit_valid_i (flit_valid),
    .flit_vc_i    (flit_vc),
    .flit_type_i  (flit_type),
    .flit_data_i  (flit_data),
    .flit_ready_o (flit_ready),
    .csr_valid_i  (csr_valid),
    .csr_wr_i     (csr_wr),
    .csr_addr_i   (csr_addr),
    .csr_wdata_i  (csr_wdata),
    .csr_rdata_o  (csr_rdata),
    .csr_err_o    (csr_err),
    .irq_vcs_o    (irq_vcs),
    .irq_trig_o   (irq_trig)
  );

  initial begin
    clk_axi = 1'b0;
    forever #5 clk_axi = ~clk_axi;  // 10 ns period
  end

  // Watchdog on the total run length
  initial begin
    cycles = 0;
    while (!(cycle_limit > 0 && cycles > cycle_limit)) begin
      @(posedge clk_axi);
      cycles++;
    end
    $display("Run stopped after %0d cycles because the stimulus did not finish", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  // Rising edge where inputs change, a held flit leaves once it was seen accepted
  task automatic next_edge();
    @(posedge clk_axi);
    if (hold_pend && ready_seen) begin
      flit_valid <= 1'b0;  // The DUT takes the held flit on this edge
      hold_pend = 1'b0;
    end
  endtask

  // Falling edge where outputs are stable
  task automatic settle();
    @(negedge clk_axi);
    ready_seen = flit_valid && flit_ready;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", tname, what, expected, actual);
    end
  endtask

  task automatic send_flit(input logic [1:0] vc, input logic [1:0] ftype,
                           input logic [31:0] data);
    int waited;
    waited = 0;
    while (hold_pend && waited < WaitLimit) begin
      next_edge();  // Let a held flit go first
      settle();
      waited++;
    end
    if (hold_pend) begin
      errors++;
      $display("Held flit was still not accepted when test %s sent a new flit", tname);
      hold_pend = 1'b0;
    end
    next_edge();
    flit_valid <= 1'b1;
    flit_vc    <= vc;
    flit_type  <= flit_type_t'(ftype);
    flit_data  <= data;
    settle();
    while (!ready_seen && waited < WaitLimit) begin
      next_edge();  // Sender holds the flit while the channel is full
      settle();
      waited++;
    end
    next_edge();
    flit_valid <= 1'b0;
    if (!ready_seen) begin
      errors++;
      $display("Flit for channel %0d in test %s was not accepted within %0d cycles",
               vc, tname, WaitLimit);
    end
  endtask

  // Offer a flit to a full channel and keep offering it
  task automatic hold_flit(input logic [1:0] vc, input logic [1:0] ftype,
                           input logic [31:0] data);
    next_edge();
    flit_valid <= 1'b1;
    flit_vc    <= vc;
    flit_type  <= flit_type_t'(ftype);
    flit_data  <= data;
    settle();
    check_value("flit_ready", 32'd0, flit_ready);
    hold_pend = 1'b1;
  endtask

  task automatic csr_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] experr);
    next_edge();
    csr_valid <= 1'b1;
    csr_wr    <= 1'b1;
    csr_addr  <= addr[CsrAddrWidth-1:0];
    csr_wdata <= data;
    settle();
    check_value("write error", experr, csr_err);  // Shown in the strobe cycle
    next_edge();
    csr_valid <= 1'b0;
    csr_wr    <= 1'b0;
    settle();
  endtask

  task automatic csr_read(input logic [31:0] addr, input logic [31:0] expdata,
                          input logic [31:0] experr);
    next_edge();
    csr_valid <= 1'b1;
    csr_wr    <= 1'b0;
    csr_addr  <= addr[CsrAddrWidth-1:0];
    settle();
    next_edge();
    csr_valid <= 1'b0;
    settle();
    check_value("read data", expdata, csr_rdata);  // Registered one cycle after the strobe
    check_value("read error", experr, csr_err);
  endtask

  task automatic check_irq(input logic [31:0] expvec);
    next_edge();
    settle();
    check_value("irq vector", expvec, irq_vcs);
    check_value("irq trigger", |expvec[NumVirtChn-1:0], irq_trig);
  endtask

  task automatic check_ready(input logic [1:0] vc, input logic [31:0] expready);
    next_edge();
    flit_vc <= vc;  // Ready follows the addressed channel even without an offer
    settle();
    check_value("flit_ready", expready, flit_ready);
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    cycle_limit = 0;
    hold_pend   = 1'b0;
    ready_seen  = 1'b0;
    nlines      = 0;
    arst_axi    = 1'b1;
    flit_valid  = 1'b0;
    flit_vc     = '0;
    flit_type   = HEAD_FLIT;
    flit_data   = '0;
    csr_valid   = 1'b0;
    csr_wr      = 1'b0;
    csr_addr    = '0;
    csr_wdata   = '0;
    rnd         = $urandom(Seed);
    fd          = $fopen(StimFile, "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the stimulus file %s", StimFile);
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line_buf, fd);
        if (code > 0) nlines++;
      end
      $fclose(fd);
      cycle_limit = nlines * 8 + 20;  // Longest command with its gap fits in 8 cycles
      repeat (10) @(posedge clk_axi);
      arst_axi <= 1'b0;
      fd = $fopen(StimFile, "r");
      while ($fscanf(fd, "%s", tname) == 1) begin
        if (tname == "#") begin
          code = $fgets(line_buf, fd);  // Rest of a comment line
        end else begin
          code = $fscanf(fd, "%s", cmd);
          gap  = $urandom % 4;
          repeat (gap) begin
            next_edge();
            settle();
          end
          if (cmd == "IRQ") begin
            code = $fscanf(fd, "%h", op_a);
            check_irq(op_a);
          end else if (cmd == "RDY") begin
            code = $fscanf(fd, "%h %h", op_a, op_b);
            check_ready(op_a[1:0], op_b);
          end else begin
            code = $fscanf(fd, "%h %h %h", op_a, op_b, op_c);
            if (cmd == "FLIT") send_flit(op_a[1:0], op_b[1:0], op_c);
            else if (cmd == "HOLD") hold_flit(op_a[1:0], op_b[1:0], op_c);
            else if (cmd == "WR") csr_write(op_a, op_b, op_c);
            else if (cmd == "RD") csr_read(op_a, op_b, op_c);
            else begin
              errors++;
              $display("Unknown command %s in test %s", cmd, tname);
            end
          end
        end
      end
      $fclose(fd);
      if (hold_pend) begin
        errors++;
        $display("Held flit was never accepted before the stimulus ended");
      end
    end
    $display("Run finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/ni_pkg.sv
source/vc_buf_if.sv
source/flit_vc_demux.sv
source/vc_rx_buffer.sv
source/ni_csr.sv
source/ni_rx_top.sv
bench/ni_rx_tb.sv

/* bench/ni_rx_stimulus.txt */
# name cmd operands: FLIT vc type data | WR addr data experr | RD addr expdata experr
# IRQ expvector | RDY vc expready | HOLD vc type data (offer kept while ready is low)
rst_irq IRQ 0
rst_rdy RDY 3 1
rst_ver RD 0000 00525831 0
rst_x RD 0004 00000002 0
rst_y RD 0008 00000003 0
rst_mask RD 0014 ffffffff 0
rst_mux RD 0010 00000000 0
err_wr_ver WR 0000 00000001 1
err_wr_x WR 0004 00000001 1
err_wr_y WR 0008 00000001 1
err_wr_stat WR 000c 00000001 1
err_wr_full WR 0018 00000001 1
err_wr_gap WR 0030 00000001 1
err_rd_gap RD 0034 00000000 1
err_rd_empty RD 0040 00000000 1
rt_a FLIT 0 0 00000012
rt_b FLIT 1 3 00000a05
rt_c FLIT 2 0 0000bb21
rt_d FLIT 0 2 a0000001
rt_e FLIT 3 3 00000044
rt_f FLIT 1 0 00001107
rt_irq IRQ f
rt_pkt0 RD 0020 00000012 0
rt_pkt1 RD 0024 00000007 0
rt_pkt2 RD 0028 00000021 0
rt_pkt3 RD 002c 00000044 0
rt_d1a RD 0044 00000a05 0
rt_d0a RD 0040 00000012 0
rt_d1b RD 0044 00001107 0
rt_d0b RD 0040 a0000001 0
rt_d2a RD 0048 0000bb21 0
rt_d3a RD 004c 00000044 0
rt_done IRQ 0
bp_0 FLIT 2 0 00000008
bp_1 FLIT 2 1 d0000001
bp_2 FLIT 2 1 d0000002
bp_3 FLIT 2 1 d0000003
bp_4 FLIT 2 1 d0000004
bp_5 FLIT 2 1 d0000005
bp_6 FLIT 2 1 d0000006
bp_7 FLIT 2 2 d0000007
bp_full RD 0018 00000004 0
bp_rdy2 RDY 2 0
bp_rdy1 RDY 1 1
bp_mux WR 0010 00000002 0
bp_hold HOLD 2 3 00000099
bp_irq IRQ 4
bp_pop RD 0048 00000008 0
bp_irq2 IRQ 4
bp_pkt RD 0028 00000099 0
irq_msk0 WR 0014 00000000 0
irq_full0 IRQ 0
irq_emp WR 0010 00000001 0
irq_emp0 IRQ 0
irq_msk1 WR 0014 00000001 0
irq_f0 FLIT 0 1 e0000001
irq_emp1 IRQ 5
irq_cmp WR 0010 00000003 0
irq_thr WR 0014 00000003 0
irq_cmp1 IRQ 4
irq_f1 FLIT 0 0 e0000010
irq_f2 FLIT 0 2 e0000002
irq_cmp2 IRQ 5
irq_head WR 0010 00000004 0
irq_f3 FLIT 1 0 00000033
irq_head1 IRQ 2
irq_pop1 RD 0044 00000033 0
irq_head0 IRQ 0
irq_pop0 RD 0040 e0000001 0
irq_head2 IRQ 1
irq_stat RD 000c 00000001 0
irq_pkt0 RD 0020 00000010 0
irq_undef WR 0010 00000007 0
irq_undef1 IRQ 5
irq_rdmux RD 0010 00000007 0
irq_rdmsk RD 0014 00000003 0
